// File: source/adc_pkg.sv
/*
 * adc_pkg
 * sample widths and types of the tank ADC path
 * capacitor voltage on channel A, tank current on channel B
 */

`default_nettype none

package adc_pkg;

   // ===============================================
   // widths and codes
   // ===============================================
   localparam int ADC_W = 14;                                // converter resolution

   typedef logic signed [ADC_W-1:0] adc_word_t;              // two's complement word

   localparam adc_word_t ADC_MAX = {1'b0, {(ADC_W-1){1'b1}}}; // +8191
   localparam adc_word_t ADC_MIN = {1'b1, {(ADC_W-1){1'b0}}}; // -8192, no positive twin

   localparam logic [ADC_W-1:0] DAC_OFFSET = 14'd8191;       // signed -> offset binary

   // averaged sample, 29 bits
   typedef struct packed {
      adc_word_t vc;    // capacitor voltage mean
      adc_word_t ic;    // tank current mean
      logic      ovr;   // any out-of-range in the window
   } sample_t;

endpackage

`default_nettype wire

// File: source/bridge_pkg.sv
/*
 * bridge_pkg
 * H-bridge gate patterns, sigma codes and surface slope format
 * leg 1 = M1 (high) / M3 (low), leg 2 = M2 (high) / M4 (low)
 */

`default_nettype none

package bridge_pkg;

   // ===============================================
   // gates
   // ===============================================
   typedef logic [3:0] gate_t;

   localparam int G_M1 = 0;   // leg 1 high side
   localparam int G_M2 = 1;   // leg 2 high side
   localparam int G_M3 = 2;   // leg 1 low side
   localparam int G_M4 = 3;   // leg 2 low side

   localparam gate_t PAT_OFF  = 4'b0000;
   localparam gate_t PAT_POS  = 4'b1001;   // M1 + M4
   localparam gate_t PAT_NEG  = 4'b0110;   // M2 + M3
   localparam gate_t PAT_BOOT = 4'b1100;   // M3 + M4, charge bootstrap caps

   // switching variable, two's complement of {-1, 0, +1}
   typedef logic [1:0] sigma_t;
   localparam sigma_t SIGMA_ZERO = 2'b00;
   localparam sigma_t SIGMA_POS  = 2'b01;
   localparam sigma_t SIGMA_NEG  = 2'b11;

   localparam int SLOPE_W    = 10;
   localparam int SLOPE_FRAC = 8;                 // slope lsb = 1/256
   typedef logic signed [SLOPE_W-1:0] slope_t;

endpackage

`default_nettype wire

// File: source/sample_if.sv
/*
 * sample_if
 * averaged sample link between capture, FIFO and control law
 * push side: stb is a one-cycle "new mean" pulse, take unused
 * pop side: stb is the FIFO not-empty level, take removes the head
 */

`timescale 1ns/10ps
`default_nettype none

interface sample_if import adc_pkg::*; ();

   sample_t smp;    // sample payload
   logic    stb;    // valid pulse or not-empty level
   logic    take;   // head removal pulse, pop link only

   // producer -> buffer
   modport push_src (output smp, output stb);
   modport push_dst (input  smp, input  stb);

   // buffer -> consumer
   modport pop_src  (output smp, output stb, input  take);
   modport pop_dst  (input  smp, input  stb, output take);

endinterface

`default_nettype wire

// File: source/adc_capture.sv
/*
 * adc_capture
 * samples both tank ADC words, restores the inverted sign,
 * drives offset-binary DAC monitor copies and averages
 * 2^DECIM_LOG2 samples per window into one mean
 */

`timescale 1ns/10ps
`default_nettype none

module adc_capture import adc_pkg::*; #(
   parameter int DECIM_LOG2 = 2
) (
   input  wire              ADA_DCO,
   input  wire              i_rst,
   input  adc_word_t        i_ada_data,   // capacitor voltage, sign inverted
   input  adc_word_t        i_adb_data,   // tank current, sign inverted
   input  wire              i_ada_or,
   input  wire              i_adb_or,
   output logic [ADC_W-1:0] o_dac_a,
   output logic [ADC_W-1:0] o_dac_b,
   sample_if.push_src       push
);

   localparam int SUM_W = ADC_W + DECIM_LOG2;
   localparam int CNT_W = (DECIM_LOG2 > 0) ? DECIM_LOG2 : 1;
   localparam logic [CNT_W-1:0] LAST = CNT_W'((1 << DECIM_LOG2) - 1);

   // board inverts the sign; -(-8192) clips to +8191
   function automatic adc_word_t sat_neg(input adc_word_t x);
      adc_word_t r;
      if (x == ADC_MIN) r = ADC_MAX;
      else r = -x;
      return r;
   endfunction

   adc_word_t               va_c, ib_c;     // sign-restored inputs
   adc_word_t               va_q, ib_q;     // registered words for the monitor
   logic signed [SUM_W-1:0] acc_a, acc_b;
   logic signed [SUM_W-1:0] sum_a, sum_b;
   logic                    ovr_acc, ovr_c;
   logic [CNT_W-1:0]        win_cnt;

   assign va_c = sat_neg(i_ada_data);
   assign ib_c = sat_neg(i_adb_data);

   // first sample of a window loads, the rest add
   assign sum_a = ((win_cnt == '0) ? '0 : acc_a) + SUM_W'(va_c);
   assign sum_b = ((win_cnt == '0) ? '0 : acc_b) + SUM_W'(ib_c);
   assign ovr_c = ((win_cnt == '0) ? 1'b0 : ovr_acc) | i_ada_or | i_adb_or;

   // ===============================================
   // raw words and DAC monitor
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      va_q    <= va_c;
      ib_q    <= ib_c;
      o_dac_a <= $unsigned(va_q) + DAC_OFFSET;   // one cycle behind the sample
      o_dac_b <= $unsigned(ib_q) + DAC_OFFSET;
   end

   // ===============================================
   // window averaging
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         win_cnt  <= '0;     // window starts at first edge out of reset
         push.stb <= 1'b0;
      end else begin
         win_cnt  <= (win_cnt == LAST) ? '0 : win_cnt + 1'b1;
         push.stb <= (win_cnt == LAST);           // one-cycle new-mean pulse
      end
   end

   always_ff @(posedge ADA_DCO) begin
      acc_a   <= sum_a;
      acc_b   <= sum_b;
      ovr_acc <= ovr_c;
      if (win_cnt == LAST) begin
         push.smp.vc  <= ADC_W'(sum_a >>> DECIM_LOG2);   // arithmetic mean
         push.smp.ic  <= ADC_W'(sum_b >>> DECIM_LOG2);
         push.smp.ovr <= ovr_c;
      end
   end

endmodule

`default_nettype wire

// File: source/sample_fifo.sv
/*
 * sample_fifo
 * circular buffer of averaged samples between capture and
 * control law; head shown combinationally, stb = not empty,
 * a push into a full buffer is lost and flags o_overflow
 */

`timescale 1ns/10ps
`default_nettype none

module sample_fifo import adc_pkg::*; #(
   parameter int DEPTH = 4
) (
   input  wire        ADA_DCO,
   input  wire        i_rst,
   sample_if.push_dst push,
   sample_if.pop_src  pop,
   output logic       o_overflow
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   sample_t          mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full, do_push, do_pop;

   // wrap at DEPTH, not only at powers of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full    = (count == CNT_W'(DEPTH));
   assign do_push = push.stb && !full;          // full -> dropped
   assign do_pop  = pop.take && (count != '0);

   assign pop.smp = mem[rd_ptr];                // head entry
   assign pop.stb = (count != '0);              // not empty

   // ===============================================
   // storage
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (do_push) mem[wr_ptr] <= push.smp;
   end

   // ===============================================
   // pointers, fill level, overflow
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         o_overflow <= 1'b0;
      end else begin
         if (do_push) wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // idle or push+take
         endcase
         if (push.stb && full) o_overflow <= 1'b1;   // sticky until reset
      end
   end

endmodule

`default_nettype wire

// File: source/hybrid_control.sv
/*
 * hybrid_control
 * hybrid switching law on the vc/ic plane
 * surface s = ic*256 - slope*vc through the origin
 * s >= 0 -> sigma +1 / PAT_POS, s < 0 -> sigma -1 / PAT_NEG
 * out-of-range window -> sigma 0 / PAT_OFF
 * one sample per 4 cycles: take, product, evaluate, hold
 */

`timescale 1ns/10ps
`default_nettype none

module hybrid_control import adc_pkg::*, bridge_pkg::*; (
   input  wire       ADA_DCO,
   input  wire       i_rst,
   input  slope_t    i_slope,     // surface slope, lsb 1/256
   sample_if.pop_dst pop,
   output gate_t     o_request,
   output sigma_t    o_sigma
);

   localparam int PROD_W = SLOPE_W + ADC_W;   // 24
   localparam int SURF_W = PROD_W + 1;        // 25, no overflow on subtract

   typedef enum logic [1:0] {
      ST_IDLE,   // wait for a head entry
      ST_MUL,    // sample latched, forming slope*vc
      ST_EVAL,   // product ready, deciding sigma
      ST_HOLD    // sigma out, one spare cycle
   } state_t;

   state_t                   state;
   logic                     take_c;
   adc_word_t                vc_q, ic_q;
   logic                     ovr_q;
   logic signed [PROD_W-1:0] prod_q;
   logic signed [SURF_W-1:0] ic_scaled, surf_c;

   // take in the same cycle the head shows up
   assign take_c   = (state == ST_IDLE) && pop.stb;
   assign pop.take = take_c;

   assign ic_scaled = SURF_W'(ic_q) <<< SLOPE_FRAC;   // ic * 256
   assign surf_c    = ic_scaled - SURF_W'(prod_q);

   // ===============================================
   // datapath
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (take_c) begin                  // stage 1 latch head
         vc_q  <= pop.smp.vc;
         ic_q  <= pop.smp.ic;
         ovr_q <= pop.smp.ovr;
      end
      if (state == ST_MUL)
         prod_q <= i_slope * vc_q;       // stage 2, slope sampled here
   end

   // ===============================================
   // sequencer and decision
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         state     <= ST_IDLE;
         o_sigma   <= SIGMA_ZERO;
         o_request <= PAT_OFF;
      end else begin
         case (state)
            ST_IDLE: begin
               if (take_c) state <= ST_MUL;
            end
            ST_MUL: begin
               state <= ST_EVAL;
            end
            ST_EVAL: begin                   // stage 3, 3 cycles after take
               state <= ST_HOLD;
               if (ovr_q) begin
                  o_sigma   <= SIGMA_ZERO;   // measurement not trusted
                  o_request <= PAT_OFF;
               end else if (!surf_c[SURF_W-1]) begin
                  o_sigma   <= SIGMA_POS;
                  o_request <= PAT_POS;
               end else begin
                  o_sigma   <= SIGMA_NEG;
                  o_request <= PAT_NEG;
               end
            end
            ST_HOLD: begin
               state <= ST_IDLE;             // next take no earlier than now
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/gate_guard.sv
/*
 * gate_guard
 * last stage before the four MOSFET drivers
 * enable gating, bootstrap start-up on the low sides,
 * turn-on dead time per gate and a leg short interlock
 */

`timescale 1ns/10ps
`default_nettype none

module gate_guard import bridge_pkg::*; #(
   parameter int DEADTIME = 5,    // cycles a request must hold before turn-on
   parameter int STARTUP  = 10    // cycles of PAT_BOOT after enable
) (
   input  wire   ADA_DCO,
   input  wire   i_rst,
   input  wire   i_enable,
   input  gate_t i_request,
   output gate_t o_gate,
   output logic  o_alert         // leg short seen, held until reset
);

   localparam int DT_W = $clog2(DEADTIME + 2);
   localparam int SU_W = $clog2(STARTUP + 2);

   logic [3:0][DT_W-1:0] dt_cnt;     // consecutive request cycles per gate
   logic [SU_W-1:0]      su_cnt;     // start-up progress
   logic                 booting;
   gate_t                run_gate, gate_next;
   logic                 short_c;

   assign booting = (su_cnt < SU_W'(STARTUP));

   // gate on only once its counter has reached the dead time
   always_comb begin
      run_gate = PAT_OFF;
      for (int g = 0; g < 4; g++)
         run_gate[g] = i_request[g] && (dt_cnt[g] == DT_W'(DEADTIME));
   end

   assign gate_next = booting ? PAT_BOOT : run_gate;

   // high and low side of one leg together
   assign short_c = (gate_next[G_M1] & gate_next[G_M3]) |
                    (gate_next[G_M2] & gate_next[G_M4]);

   // ===============================================
   // counters and gate register
   // ===============================================
   always_ff @(posedge ADA_DCO) begin
      if (i_rst) begin
         o_gate  <= PAT_OFF;
         o_alert <= 1'b0;
         su_cnt  <= '0;
         dt_cnt  <= '0;
      end else if (!i_enable) begin
         o_gate <= PAT_OFF;               // bridge off next cycle
         su_cnt <= '0;                    // re-enable restarts the boot
         dt_cnt <= '0;
      end else begin
         if (booting) su_cnt <= su_cnt + 1'b1;
         for (int g = 0; g < 4; g++) begin
            if (booting || !i_request[g])
               dt_cnt[g] <= '0;           // turn-off is immediate
            else if (dt_cnt[g] != DT_W'(DEADTIME))
               dt_cnt[g] <= dt_cnt[g] + 1'b1;
         end
         if (short_c) o_alert <= 1'b1;
         o_gate <= (o_alert || short_c) ? PAT_OFF : gate_next;
      end
   end

endmodule

`default_nettype wire

// File: source/hybrid_control_top.sv
/*
 * hybrid_control_top
 * sensing and switching path of the resonant-tank H-bridge
 * capture -> sample FIFO -> switching law -> gate guard,
 * all on the ADC data clock
 */

`timescale 1ns/10ps
`default_nettype none

module hybrid_control_top import adc_pkg::*, bridge_pkg::*; #(
   parameter int DECIM_LOG2 = 2,    // 4-sample window
   parameter int DEPTH      = 4,
   parameter int DEADTIME   = 5,
   parameter int STARTUP    = 10
) (
   input  wire              ADA_DCO,
   input  wire              i_rst,
   input  adc_word_t        i_ada_data,
   input  adc_word_t        i_adb_data,
   input  wire              i_ada_or,
   input  wire              i_adb_or,
   input  wire              i_enable,
   input  slope_t           i_slope,
   output gate_t            o_gate,       // {M4, M3, M2, M1}
   output sigma_t           o_sigma,
   output logic [ADC_W-1:0] o_dac_a,      // vc monitor
   output logic [ADC_W-1:0] o_dac_b,      // ic monitor
   output logic             o_overflow,
   output logic             o_alert
);

   // ===============================================
   // links
   // ===============================================
   sample_if push_link ();   // capture -> fifo
   sample_if pop_link  ();   // fifo -> control law

   gate_t request;

   adc_capture #(.DECIM_LOG2(DECIM_LOG2)) adc_capture_inst (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .o_dac_a    (o_dac_a),
      .o_dac_b    (o_dac_b),
      .push       (push_link.push_src)
   );

   sample_fifo #(.DEPTH(DEPTH)) sample_fifo_inst (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .push       (push_link.push_dst),
      .pop        (pop_link.pop_src),
      .o_overflow (o_overflow)
   );

   hybrid_control hybrid_control_inst (
      .ADA_DCO   (ADA_DCO),
      .i_rst     (i_rst),
      .i_slope   (i_slope),
      .pop       (pop_link.pop_dst),
      .o_request (request),
      .o_sigma   (o_sigma)
   );

   gate_guard #(.DEADTIME(DEADTIME), .STARTUP(STARTUP)) gate_guard_inst (
      .ADA_DCO   (ADA_DCO),
      .i_rst     (i_rst),
      .i_enable  (i_enable),
      .i_request (request),
      .o_gate    (o_gate),
      .o_alert   (o_alert)
   );

endmodule

`default_nettype wire

// File: bench/hybrid_control_chk.sv
/*
 * hybrid_control_chk
 * bound checks on the bridge gates and the FIFO pop link
 */

`timescale 1ns/10ps
`default_nettype none

module hybrid_control_chk import bridge_pkg::*; (
   input wire   ADA_DCO,
   input wire   i_rst,
   input wire   i_enable,
   input gate_t i_gate,
   input wire   i_take,    // pop link take pulse
   input wire   i_stb      // fifo not empty
);

   // ===============================================
   // leg interlock
   // ===============================================
   leg1_no_short: assert property (@(posedge ADA_DCO) disable iff (i_rst)
      !(i_gate[G_M1] && i_gate[G_M3]))
      else $error("leg 1 high and low side on together");

   leg2_no_short: assert property (@(posedge ADA_DCO) disable iff (i_rst)
      !(i_gate[G_M2] && i_gate[G_M4]))
      else $error("leg 2 high and low side on together");

   // bridge dark one cycle after enable drops
   gates_off_disabled: assert property (@(posedge ADA_DCO) disable iff (i_rst)
      !i_enable |=> (i_gate == PAT_OFF))
      else $error("gates not off after enable low");

   // ===============================================
   // pop link
   // ===============================================
   take_needs_head: assert property (@(posedge ADA_DCO) disable iff (i_rst)
      i_take |-> i_stb)
      else $error("take raised while the FIFO is empty");

endmodule

`default_nettype wire

// File: bench/hybrid_control_tb.sv
/*
 * hybrid_control_tb
 * testbench of the H-bridge sensing and switching path
 * LFSR words on both ADC channels, cycle model of capture,
 * FIFO, switching law and gate guard, compared every cycle
 */

`timescale 1ns/10ps
`default_nettype none

module hybrid_control_tb import adc_pkg::*, bridge_pkg::*; ();

   localparam int DECIM_LOG2 = 2;
   localparam int DEPTH      = 4;
   localparam int DEADTIME   = 5;
   localparam int STARTUP    = 10;
   localparam int HALF       = 20;              // 40 ns period
   localparam int RST_CYC    = 16;
   localparam int TEST_CYC   = 700;
   localparam int WIN        = 1 << DECIM_LOG2;  // samples per mean

   logic             ADA_DCO;
   logic             i_rst;
   adc_word_t        i_ada_data, i_adb_data;
   logic             i_ada_or, i_adb_or;
   logic             i_enable;
   slope_t           i_slope;
   gate_t            o_gate;
   sigma_t           o_sigma;
   logic [ADC_W-1:0] o_dac_a, o_dac_b;
   logic             o_overflow, o_alert;

   logic [31:0]      lfsr;
   logic             run_ok, fail_shown;

   // reference model state
   int               steps;
   int               win_idx, sum_a, sum_b;
   logic             win_ovr, m_stb, m_ovf;
   sample_t          m_mean, lat;
   sample_t          fifo_q[$];
   logic [ADC_W-1:0] pipe_a, pipe_b, exp_dac_a, exp_dac_b;
   int               ctl_st, prod, su_cnt;
   int               held [4];                 // request run length per gate
   sigma_t           m_sigma;
   gate_t            m_req, m_gate;
   int               n_pos, n_neg, n_zero;
   logic             seen_boot, seen_gpos, seen_gneg;

   hybrid_control_top #(
      .DECIM_LOG2 (DECIM_LOG2),
      .DEPTH      (DEPTH),
      .DEADTIME   (DEADTIME),
      .STARTUP    (STARTUP)
   ) hybrid_control_top_inst (
      .ADA_DCO    (ADA_DCO),
      .i_rst      (i_rst),
      .i_ada_data (i_ada_data),
      .i_adb_data (i_adb_data),
      .i_ada_or   (i_ada_or),
      .i_adb_or   (i_adb_or),
      .i_enable   (i_enable),
      .i_slope    (i_slope),
      .o_gate     (o_gate),
      .o_sigma    (o_sigma),
      .o_dac_a    (o_dac_a),
      .o_dac_b    (o_dac_b),
      .o_overflow (o_overflow),
      .o_alert    (o_alert)
   );

   bind hybrid_control_top hybrid_control_chk chk_inst (
      .ADA_DCO  (ADA_DCO),
      .i_rst    (i_rst),
      .i_enable (i_enable),
      .i_gate   (o_gate),
      .i_take   (pop_link.take),
      .i_stb    (pop_link.stb)
   );

   initial ADA_DCO = 1'b0;
   always #(HALF) ADA_DCO = ~ADA_DCO;

   // ===============================================
   // random source
   // ===============================================
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, right shift
   endfunction

   task automatic draw(input int n, output logic [31:0] v);
      v = '0;
      for (int b = 0; b < n; b++) begin
         lfsr = lfsr_next(lfsr);                      // one step per bit
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // board sign inversion undone, -(-8192) clips to +8191
   function automatic int restore(input adc_word_t w);
      int v;
      v = w;
      return (v == -8192) ? 8191 : -v;
   endfunction

   function automatic logic [ADC_W-1:0] dac_of(input int v);
      return ADC_W'(v + int'(DAC_OFFSET));             // offset binary, mod 2^14
   endfunction

   // ===============================================
   // compare tasks
   // ===============================================
   task automatic check_word(input string name, input logic [ADC_W-1:0] got, exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %0d expected %0d", $time, name, got, exp);
         fail_shown = 1'b1;
         $display(">>> FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_sigma(input string name, input sigma_t got, exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
         fail_shown = 1'b1;
         $display(">>> FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_gate(input string name, input gate_t got, exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
         fail_shown = 1'b1;
         $display(">>> FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   task automatic check_flag(input string name, input logic got, exp);
      if (got !== exp) begin
         $display("Fail %0t %s got %b expected %b", $time, name, got, exp);
         fail_shown = 1'b1;
         $display(">>> FAIL");
         $fatal(1, "%s mismatch", name);
      end
   endtask

   // ===============================================
   // reference model, one call per rising edge
   // ===============================================
   task automatic model_step();
      logic      take, full;
      int        na, nb, vc, ic, sl, surf;
      adc_word_t w;
      take      = (ctl_st == 0) && (fifo_q.size() > 0);   // head visible, law idle
      na        = restore(i_ada_data);
      nb        = restore(i_adb_data);
      exp_dac_a = pipe_a;                                 // one cycle behind
      exp_dac_b = pipe_b;
      pipe_a    = dac_of(na);
      pipe_b    = dac_of(nb);
      steps++;
      if (i_rst) begin
         win_idx = 0;
         m_stb   = 1'b0;
         m_ovf   = 1'b0;
         fifo_q.delete();
         ctl_st  = 0;
         m_sigma = SIGMA_ZERO;
         m_req   = PAT_OFF;
         m_gate  = PAT_OFF;
         su_cnt  = 0;
         for (int g = 0; g < 4; g++) held[g] = 0;
      end else begin
         // gate guard, on last cycle's request
         if (!i_enable) begin
            m_gate = PAT_OFF;
            su_cnt = 0;
            for (int g = 0; g < 4; g++) held[g] = 0;
         end else if (su_cnt < STARTUP) begin
            m_gate = PAT_BOOT;                            // bootstrap charge
            su_cnt++;
            for (int g = 0; g < 4; g++) held[g] = 0;
         end else begin
            for (int g = 0; g < 4; g++) begin
               m_gate[g] = m_req[g] && (held[g] == DEADTIME);
               if (!m_req[g]) held[g] = 0;                // off at once
               else if (held[g] < DEADTIME) held[g]++;
            end
         end
         // switching law sequencer
         case (ctl_st)
            0: if (take) begin
               lat    = fifo_q[0];
               ctl_st = 1;
            end
            1: begin
               w      = lat.vc;
               vc     = w;
               sl     = i_slope;                          // slope at product stage
               prod   = sl * vc;
               ctl_st = 2;
            end
            2: begin
               w    = lat.ic;
               ic   = w;
               surf = ic * 256 - prod;
               if (lat.ovr) begin
                  m_sigma = SIGMA_ZERO;
                  m_req   = PAT_OFF;
                  n_zero++;
               end else if (surf >= 0) begin
                  m_sigma = SIGMA_POS;
                  m_req   = PAT_POS;
                  n_pos++;
               end else begin
                  m_sigma = SIGMA_NEG;
                  m_req   = PAT_NEG;
                  n_neg++;
               end
               ctl_st = 3;
            end
            default: ctl_st = 0;
         endcase
         // fifo, full judged before the take
         full = (fifo_q.size() == DEPTH);
         if (take) void'(fifo_q.pop_front());
         if (m_stb) begin
            if (full) m_ovf = 1'b1;
            else fifo_q.push_back(m_mean);
         end
         // window mean
         if (win_idx == 0) begin
            sum_a   = na;
            sum_b   = nb;
            win_ovr = i_ada_or | i_adb_or;
         end else begin
            sum_a   += na;
            sum_b   += nb;
            win_ovr |= i_ada_or | i_adb_or;
         end
         m_stb = (win_idx == WIN - 1);
         if (m_stb) begin
            m_mean.vc  = ADC_W'(sum_a >>> DECIM_LOG2);    // floor of the mean
            m_mean.ic  = ADC_W'(sum_b >>> DECIM_LOG2);
            m_mean.ovr = win_ovr;
         end
         win_idx = (win_idx + 1) % WIN;
      end
   endtask

   task automatic compare_outputs();
      if (steps >= 2) begin                               // monitor defined from here
         check_word("o_dac_a", o_dac_a, exp_dac_a);
         check_word("o_dac_b", o_dac_b, exp_dac_b);
      end
      check_sigma("o_sigma", o_sigma, m_sigma);
      check_gate("o_gate", o_gate, m_gate);
      check_flag("o_overflow", o_overflow, m_ovf);
      check_flag("o_alert", o_alert, 1'b0);
      if (o_gate == PAT_BOOT) seen_boot = 1'b1;
      if (o_gate == PAT_POS) seen_gpos = 1'b1;
      if (o_gate == PAT_NEG) seen_gneg = 1'b1;
   endtask

   // values sampled at edge c+1
   task automatic drive_inputs(input int c);
      logic [31:0] r;
      int          t;
      t     = c + 1 - RST_CYC;                            // edge index after reset
      i_rst = (t < 0);
      draw(ADC_W, r);
      i_ada_data = r[ADC_W-1:0];
      draw(ADC_W, r);
      i_adb_data = r[ADC_W-1:0];
      if (t % 97 == 5) i_ada_data = ADC_MIN;              // clipping corner
      if (t % 89 == 7) i_adb_data = ADC_MIN;
      draw(4, r);
      i_ada_or = (t >= 200) && (t < 400) && (r[3:0] == 4'd0);   // sparse out-of-range
      draw(4, r);
      i_adb_or = (t >= 200) && (t < 400) && (r[3:0] == 4'd0);
      if (t % 64 == 0) begin
         draw(SLOPE_W, r);
         i_slope = r[SLOPE_W-1:0];
      end
      // on after 4 cycles, then three drops
      i_enable = (t >= 4) && !((t >= 420) && (t < 432)) && !((t >= 560) && (t < 563)) &&
                 (t != 640);
   endtask

   // ===============================================
   // main sequence
   // ===============================================
   initial begin
      lfsr       = 32'd84078;
      run_ok     = 1'b0;
      fail_shown = 1'b0;
      i_rst      = 1'b1;
      i_ada_data = '0;
      i_adb_data = '0;
      i_ada_or   = 1'b0;
      i_adb_or   = 1'b0;
      i_enable   = 1'b0;
      i_slope    = 10'sd64;
      steps      = 0;
      win_idx    = 0;
      sum_a      = 0;
      sum_b      = 0;
      win_ovr    = 1'b0;
      m_stb      = 1'b0;
      m_ovf      = 1'b0;
      pipe_a     = '0;
      pipe_b     = '0;
      ctl_st     = 0;
      prod       = 0;
      su_cnt     = 0;
      m_sigma    = SIGMA_ZERO;
      m_req      = PAT_OFF;
      m_gate     = PAT_OFF;
      n_pos      = 0;
      n_neg      = 0;
      n_zero     = 0;
      seen_boot  = 1'b0;
      seen_gpos  = 1'b0;
      seen_gneg  = 1'b0;
      for (int g = 0; g < 4; g++) held[g] = 0;
      for (int c = 0; c < RST_CYC + TEST_CYC; c++) begin
         @(posedge ADA_DCO);
         #1;                                              // outputs settled
         model_step();
         compare_outputs();
         #1;
         drive_inputs(c);
      end
      if (n_pos == 0 || n_neg == 0 || n_zero == 0 || !seen_boot || !seen_gpos || !seen_gneg)
         $display("not every sigma value and gate pattern appeared during the run");
      if (n_pos > 0 && n_neg > 0 && n_zero > 0 && seen_boot && seen_gpos && seen_gneg) begin
         run_ok = 1'b1;
         $display(">>> PASS");
         $finish;
      end else begin
         fail_shown = 1'b1;
         $display(">>> FAIL");
         $fatal(1, "incomplete coverage");
      end
   end

   // watchdog, whole test length plus 100 cycles
   initial begin
      #((RST_CYC + TEST_CYC + 100) * 2 * HALF);
      $display("the run timed out before the test sequence finished");
      fail_shown = 1'b1;
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
   end

   // run stopped early from outside the main sequence
   final begin
      if (!run_ok && !fail_shown)
         $display(">>> FAIL");
   end

endmodule

`default_nettype wire

// File: verilog.f
source/adc_pkg.sv
source/bridge_pkg.sv
source/sample_if.sv
source/adc_capture.sv
source/sample_fifo.sv
source/hybrid_control.sv
source/gate_guard.sv
source/hybrid_control_top.sv
bench/hybrid_control_chk.sv
bench/hybrid_control_tb.sv

// File: Makefile
# Verilator flow for the hybrid control testbench
# make compile | make run | make clean

SIM := obj_dir/sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f \
		--top-module hybrid_control_tb -Mdir obj_dir -o sim

run: compile
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
